//--- rtl/udp_echo_pkg.sv
`default_nettype none

package udp_echo_pkg;

    // IPv4 address and UDP port
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // UDP header as seen above the stack, same shape for rx and reply
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One payload byte per beat
    typedef struct packed {
        logic [7:0] data;
        // End of datagram
        logic       last;
        // Error flag from the stack, carried through untouched
        logic       user;
    } payload_beat_t;

    // Echo service port
    parameter udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // 192.168.1.128
    parameter ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

endpackage

`default_nettype wire

//--- rtl/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 16
) (
    input  logic clk,
    input  logic rst,

    input  T     in_item,
    input  logic in_valid,
    output logic in_ready,

    output T     out_item,
    output logic out_valid,
    input  logic out_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    // Items behind the output register
    T mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // Occupancy including the output register
    logic [AW:0]   count;

    logic push;
    logic pop;
    logic stage_free;
    logic mem_empty;
    logic mem_wr;
    logic mem_rd;
    logic bypass;

    assign in_ready   = count != FULL_COUNT;
    assign push       = in_valid && in_ready;
    assign pop        = out_valid && out_ready;
    assign stage_free = !out_valid || pop;
    assign mem_empty  = count == (AW + 1)'(out_valid);

    // Empty FIFO: the write goes straight to the output register
    assign bypass = stage_free && mem_empty && push;
    assign mem_rd = stage_free && !mem_empty;
    assign mem_wr = push && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (stage_free) begin
                out_valid <= !mem_empty || push;
            end
        end
    end

    // Storage and output item
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= in_item;
        end
        if (mem_rd) begin
            out_item <= mem[rd_ptr];
        end else if (bypass) begin
            out_item <= in_item;
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_rx_steer.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rx_steer #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  logic clk,
    input  logic rst,

    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,

    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    output udp_echo_pkg::udp_hdr_t      reply_hdr,
    output logic                        reply_hdr_valid,
    input  logic                        reply_hdr_ready,

    output udp_echo_pkg::payload_beat_t fwd_payload,
    output logic                        fwd_payload_valid,
    input  logic                        fwd_payload_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FWD,
        ST_DROP
    } state_t;

    state_t state;

    logic port_match;
    logic idle;
    logic hdr_xfer;
    logic frame_end;

    assign idle       = state == ST_IDLE;
    assign port_match = rx_hdr.dst_port == ECHO_PORT;

    // Non-matching headers are taken even with the header FIFO full
    assign rx_hdr_ready = idle && (reply_hdr_ready || !port_match);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;

    // Reply goes out in the same cycle the header is accepted
    assign reply_hdr_valid = idle && rx_hdr_valid && port_match;

    always_comb begin
        reply_hdr.src_ip   = LOCAL_IP;
        reply_hdr.dst_ip   = rx_hdr.src_ip;
        reply_hdr.src_port = rx_hdr.dst_port;
        reply_hdr.dst_port = rx_hdr.src_port;
        reply_hdr.length   = rx_hdr.length;
    end

    // Payload path, forward or drain
    always_comb begin
        case (state)
            ST_FWD:  rx_payload_ready = fwd_payload_ready;
            ST_DROP: rx_payload_ready = 1'b1;
            default: rx_payload_ready = 1'b0;
        endcase
    end

    assign fwd_payload       = rx_payload;
    assign fwd_payload_valid = (state == ST_FWD) && rx_payload_valid;

    assign frame_end = rx_payload_valid && rx_payload_ready && rx_payload.last;

    // Frame tracker
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_FWD : ST_DROP;
                    end
                end
                ST_FWD, ST_DROP: begin
                    if (frame_end) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/payload_led_latch.sv
`timescale 1ns/1ps
`default_nettype none

module payload_led_latch (
    input  logic                        clk,
    input  logic                        rst,

    input  udp_echo_pkg::payload_beat_t beat,
    input  logic                        valid,
    input  logic                        ready,

    output logic [7:0]                  led
);

    logic xfer;
    // Next transfer is the first beat of a datagram
    logic first_beat;

    assign xfer = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= 8'h00;
        end else if (xfer) begin
            if (first_beat) begin
                led <= beat.data;
            end
            // Rearm on the closing beat
            first_beat <= beat.last;
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_echo_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT     = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP      = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter int                      PAYLOAD_DEPTH = 256,
    parameter int                      HDR_DEPTH     = 4
) (
    input  logic clk,
    input  logic rst,

    // From the UDP stack
    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    // Back to the UDP stack
    output udp_echo_pkg::udp_hdr_t      tx_hdr,
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t tx_payload,
    output logic                        tx_payload_valid,
    input  logic                        tx_payload_ready,

    output logic [7:0]                  led
);

    udp_echo_pkg::udp_hdr_t      reply_hdr;
    logic                        reply_hdr_valid;
    logic                        reply_hdr_ready;

    udp_echo_pkg::payload_beat_t fwd_payload;
    logic                        fwd_payload_valid;
    logic                        fwd_payload_ready;

    udp_rx_steer #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP)
    ) i_steer (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr            (rx_hdr),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_payload        (rx_payload),
        .rx_payload_valid  (rx_payload_valid),
        .rx_payload_ready  (rx_payload_ready),
        .reply_hdr         (reply_hdr),
        .reply_hdr_valid   (reply_hdr_valid),
        .reply_hdr_ready   (reply_hdr_ready),
        .fwd_payload       (fwd_payload),
        .fwd_payload_valid (fwd_payload_valid),
        .fwd_payload_ready (fwd_payload_ready)
    );

    // Reply headers, several datagrams may be queued
    stream_fifo #(
        .T     (udp_echo_pkg::udp_hdr_t),
        .DEPTH (HDR_DEPTH)
    ) hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (reply_hdr),
        .in_valid  (reply_hdr_valid),
        .in_ready  (reply_hdr_ready),
        .out_item  (tx_hdr),
        .out_valid (tx_hdr_valid),
        .out_ready (tx_hdr_ready)
    );

    stream_fifo #(
        .T     (udp_echo_pkg::payload_beat_t),
        .DEPTH (PAYLOAD_DEPTH)
    ) payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (fwd_payload),
        .in_valid  (fwd_payload_valid),
        .in_ready  (fwd_payload_ready),
        .out_item  (tx_payload),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready)
    );

    // First byte of each echoed datagram onto the LEDs
    payload_led_latch i_led (
        .clk   (clk),
        .rst   (rst),
        .beat  (tx_payload),
        .valid (tx_payload_valid),
        .ready (tx_payload_ready),
        .led   (led)
    );

endmodule

`default_nettype wire

//--- bench/udp_echo_sva.sv
`timescale 1ns/1ps
`default_nettype none

module udp_echo_sva (
    input logic                        clk,
    input logic                        rst,
    input udp_echo_pkg::udp_hdr_t      tx_hdr,
    input logic                        tx_hdr_valid,
    input logic                        tx_hdr_ready,
    input udp_echo_pkg::payload_beat_t tx_payload,
    input logic                        tx_payload_valid,
    input logic                        tx_payload_ready
);

    // Stalled outputs hold their item
    hdr_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr)
    ) else $error("tx_hdr dropped or changed before tx_hdr_ready");

    payload_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload)
    ) else $error("tx_payload dropped or changed before tx_payload_ready");

    // Both FIFOs come out of reset empty
    reset_empty: assert property (
        @(posedge clk) rst |=> !tx_hdr_valid && !tx_payload_valid
    ) else $error("tx valid high in the cycle after reset");

endmodule

bind udp_echo_top udp_echo_sva i_sva (
    .clk              (clk),
    .rst              (rst),
    .tx_hdr           (tx_hdr),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_payload       (tx_payload),
    .tx_payload_valid (tx_payload_valid),
    .tx_payload_ready (tx_payload_ready)
);

`default_nettype wire

//--- bench/udp_echo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module udp_echo_tb;

    localparam udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT;
    localparam udp_echo_pkg::ip_addr_t  LOCAL_IP  = udp_echo_pkg::DEFAULT_LOCAL_IP;
    localparam int PAYLOAD_DEPTH = 256;
    localparam int HDR_DEPTH     = 4;

    localparam logic [31:0] SEED = 32'h4e8a_3a5f;

    // Datagrams per test
    localparam int N_ECHO   = 4;
    localparam int N_FILTER = 8;
    localparam int N_BP     = 6;
    localparam int N_LED    = 4;
    localparam int N_RESET  = 1;
    localparam int N_TOTAL  = N_ECHO + N_FILTER + N_BP + N_LED + N_RESET;
    // Reset phases get a fixed margin on top
    localparam int WATCHDOG_CYCLES = 200 * N_TOTAL + 100;

    // tx ready patterns
    localparam int READY_ON     = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_STALL  = 2;

    logic clk;
    logic rst;

    udp_echo_pkg::udp_hdr_t      rx_hdr;
    logic                        rx_hdr_valid;
    logic                        rx_hdr_ready;
    udp_echo_pkg::payload_beat_t rx_payload;
    logic                        rx_payload_valid;
    logic                        rx_payload_ready;
    udp_echo_pkg::udp_hdr_t      tx_hdr;
    logic                        tx_hdr_valid;
    logic                        tx_hdr_ready;
    udp_echo_pkg::payload_beat_t tx_payload;
    logic                        tx_payload_valid;
    logic                        tx_payload_ready;
    logic [7:0]                  led;

    udp_echo_pkg::udp_hdr_t      exp_hdr_q[$];
    udp_echo_pkg::payload_beat_t exp_beat_q[$];

    int         errors;
    int         checks;
    int         tests;
    int         ready_mode;
    logic       tx_first;
    logic       led_pending;
    logic [7:0] led_exp;
    logic [7:0] last_echo_byte;

    udp_echo_top #(
        .ECHO_PORT     (ECHO_PORT),
        .LOCAL_IP      (LOCAL_IP),
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH),
        .HDR_DEPTH     (HDR_DEPTH)
    ) i_dut (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reply as the echo service should build it
    function automatic udp_echo_pkg::udp_hdr_t expected_reply(input udp_echo_pkg::udp_hdr_t rx);
        udp_echo_pkg::udp_hdr_t r;
        r.src_ip   = LOCAL_IP;
        r.dst_ip   = rx.src_ip;
        r.src_port = rx.dst_port;
        r.dst_port = rx.src_port;
        r.length   = rx.length;
        return r;
    endfunction

    function automatic udp_echo_pkg::udp_hdr_t make_hdr(input bit to_echo, input int len);
        udp_echo_pkg::udp_hdr_t h;
        h.src_ip   = $urandom;
        h.dst_ip   = $urandom;
        h.src_port = 16'($urandom);
        h.dst_port = ECHO_PORT;
        h.length   = 16'(8 + len);
        while (!to_echo && h.dst_port == ECHO_PORT) begin
            h.dst_port = 16'($urandom);
        end
        return h;
    endfunction

    task automatic check_equal(input string name, input logic [111:0] expected,
                               input logic [111:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %0h got %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Header first, then 1 to 40 payload beats
    task automatic send_datagram(input bit to_echo);
        udp_echo_pkg::udp_hdr_t      h;
        udp_echo_pkg::payload_beat_t b;
        int len;
        int i;
        len = $urandom_range(1, 40);
        h = make_hdr(to_echo, len);
        if (to_echo) begin
            exp_hdr_q.push_back(expected_reply(h));
        end
        rx_hdr = h;
        rx_hdr_valid = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready) @(negedge clk);
        @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
        for (i = 0; i < len; i++) begin
            b.data = 8'($urandom);
            b.last = i == len - 1;
            b.user = ($urandom % 8) == 0;
            if (to_echo) begin
                exp_beat_q.push_back(b);
                if (i == 0) begin
                    last_echo_byte = b.data;
                end
            end
            rx_payload = b;
            rx_payload_valid = 1'b1;
            @(negedge clk);
            while (!rx_payload_ready) @(negedge clk);
            @(posedge clk);
            #1;
            rx_payload_valid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0 || led_pending) begin
            @(negedge clk);
        end
        // Quiet period to catch stray output
        repeat (20) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    always @(posedge clk) begin
        #1;
        case (ready_mode)
            READY_RANDOM: begin
                tx_hdr_ready     = ($urandom % 3) != 0;
                tx_payload_ready = ($urandom % 3) != 0;
            end
            READY_STALL: begin
                tx_hdr_ready     = 1'b0;
                tx_payload_ready = 1'b0;
            end
            default: begin
                tx_hdr_ready     = 1'b1;
                tx_payload_ready = 1'b1;
            end
        endcase
    end

    // Scoreboard sampled mid-cycle ahead of the transfer edge
    always @(negedge clk) begin : compare_tx
        udp_echo_pkg::payload_beat_t exp_b;
        if (rst) begin
            tx_first    = 1'b1;
            led_pending = 1'b0;
        end else begin
            if (led_pending) begin
                check_equal("led", 112'(led_exp), 112'(led));
                led_pending = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                assert (exp_hdr_q.size() != 0) else begin
                    $display("ERROR at %0t: tx header sent with no echo expected", $time);
                    errors++;
                end
                if (exp_hdr_q.size() != 0) begin
                    check_equal("tx_hdr", 112'(exp_hdr_q.pop_front()), 112'(tx_hdr));
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                assert (exp_beat_q.size() != 0) else begin
                    $display("ERROR at %0t: tx payload beat sent with no echo expected", $time);
                    errors++;
                end
                if (exp_beat_q.size() != 0) begin
                    exp_b = exp_beat_q.pop_front();
                    check_equal("tx_payload", 112'(exp_b), 112'(tx_payload));
                    if (tx_first) begin
                        led_exp     = exp_b.data;
                        led_pending = 1'b1;
                    end
                    tx_first = exp_b.last;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        int err0;
        int i;
        void'($urandom(SEED));
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        ready_mode       = READY_ON;
        errors           = 0;
        checks           = 0;
        tests            = 0;
        last_echo_byte   = 8'h00;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        err0 = errors;
        for (i = 0; i < N_ECHO; i++) begin
            send_datagram(1'b1);
        end
        wait_idle();
        report_test("echo", err0);

        // Every third datagram goes to the echo port
        err0 = errors;
        for (i = 0; i < N_FILTER; i++) begin
            send_datagram(i % 3 == 1);
        end
        wait_idle();
        report_test("filter", err0);

        // Fill the header FIFO while stalled, then release with random gaps
        err0 = errors;
        ready_mode = READY_STALL;
        for (i = 0; i < HDR_DEPTH; i++) begin
            send_datagram(1'b1);
        end
        ready_mode = READY_RANDOM;
        for (i = HDR_DEPTH; i < N_BP; i++) begin
            send_datagram(1'b1);
        end
        wait_idle();
        report_test("back-pressure", err0);

        err0 = errors;
        for (i = 0; i < N_LED; i++) begin
            send_datagram(1'b1);
        end
        wait_idle();
        ready_mode = READY_ON;
        check_equal("led", 112'(last_echo_byte), 112'(led));
        report_test("led", err0);

        // Reset with a reply still queued and the steer in the forward state
        err0 = errors;
        ready_mode = READY_STALL;
        @(posedge clk);
        #1;
        send_datagram(1'b1);
        rx_hdr = make_hdr(1'b1, 1);
        rx_hdr_valid = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready) @(negedge clk);
        @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        exp_hdr_q.delete();
        exp_beat_q.delete();
        rst = 1'b0;
        ready_mode = READY_ON;
        @(negedge clk);
        check_equal("tx_hdr_valid", '0, 112'(tx_hdr_valid));
        check_equal("tx_payload_valid", '0, 112'(tx_payload_valid));
        check_equal("rx_payload_ready", '0, 112'(rx_payload_ready));
        check_equal("led", '0, 112'(led));
        @(posedge clk);
        #1;
        for (i = 0; i < N_RESET; i++) begin
            send_datagram(1'b1);
        end
        wait_idle();
        report_test("reset", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/udp_echo_pkg.sv
rtl/stream_fifo.sv
rtl/udp_rx_steer.sv
rtl/payload_led_latch.sv
rtl/udp_echo_top.sv
bench/udp_echo_sva.sv
bench/udp_echo_tb.sv

//--- Makefile
# Verilator flow for the UDP echo engine
# Any variable below can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
FILE_LIST  ?= verilog.f
TB_TOP     ?= udp_echo_tb
RTL_TOP    ?= udp_echo_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?=
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= Finished with no errors

ALL_SRCS := $(shell cat $(FILE_LIST))
RTL_SRCS := $(shell grep '^rtl/' $(FILE_LIST))
SIM_BIN  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(ALL_SRCS) $(FILE_LIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass only if the testbench printed the pass line
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
